// ==== rtl/jtag_consts.svh ====
`ifndef JTAG_CONSTS_SVH
`define JTAG_CONSTS_SVH

// shift data and response word
`define JTAG_DATA_W     32

// command length field, wide enough for long idle delays
`define JTAG_LEN_W      20

// tck periods of the fixed tap walks
`define JTAG_RESET_TCKS 5   // tms high, ends in test-logic-reset
`define JTAG_IR_PRE     4   // rti to shift-ir
`define JTAG_DR_PRE     3   // rti to shift-dr

// after the last shift bit
// exit1 -> update -> run-test/idle
`define JTAG_POST       2

`endif

// ==== rtl/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

    // command opcodes on the cmd port
    typedef enum logic [2:0] {
        CMD_CLOSE_TEST = 3'd0,
        CMD_RUN_TEST   = 3'd1,
        CMD_LOAD_IR    = 3'd2,
        CMD_LOAD_DR    = 3'd3,
        CMD_IDLE_DELAY = 3'd4
    } jtag_op_e;

    typedef enum logic [3:0] {
        S_IDLE       = 4'd0,
        S_RESET_WALK = 4'd1,  // close test
        S_RUN        = 4'd2,
        S_PRE        = 4'd3,  // rti to shift-ir/dr
        S_SHIFT      = 4'd4,
        S_POST       = 4'd5,  // exit1, update, rti
        S_DELAY      = 4'd6,
        S_WAIT_RSP   = 4'd7
    } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/jtag_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "jtag_consts.svh"

// sequencer <-> tck timer
interface jtag_step_if;
    logic                   start;  // load count, one cycle
    logic [`JTAG_LEN_W-1:0] count;  // tck periods in the segment
    logic                   run;
    logic                   rise;   // tck goes high
    logic                   fall;   // tck goes low, period ends
    logic                   done;   // fall of the last period

    modport fsm (
        output start, count, run,
        input  fall, done
    );

    modport timer (
        input  start, count, run,
        output rise, fall, done
    );
endinterface

// sequencer <-> shift register
interface jtag_shift_if;
    logic load;      // take cmd_data and length
    logic shift_en;  // current or next period is a shift bit
    logic finish;
    logic tdi_bit;
    logic rsp_busy;  // response not taken yet

    modport fsm (
        output load, shift_en, finish,
        input  rsp_busy
    );

    modport shifter (
        input  load, shift_en, finish,
        output tdi_bit, rsp_busy
    );
endinterface

`default_nettype wire

// ==== rtl/jtag_seq_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "jtag_consts.svh"

module jtag_seq_fsm
    import jtag_pkg::*;
(
    input  wire                   jtag_clk,
    input  wire                   arst_n,
    input  wire                   cmd_valid,
    input  wire jtag_op_e         cmd_op,
    input  wire [`JTAG_LEN_W-1:0] cmd_len,
    output logic                  cmd_ready,
    output logic                  tms,
    jtag_step_if.fsm              step,
    jtag_shift_if.fsm             shift
);

    seq_state_e             state;
    seq_state_e             state_n;
    jtag_op_e               op_q;
    logic [`JTAG_LEN_W-1:0] len_q;
    logic [5:0]             pos;       // period index in the segment
    logic [5:0]             pos_n;
    logic [5:0]             last_pos;  // last shift bit, leaves shift-xr
    logic                   tms_n;
    logic                   accept;

    assign cmd_ready = (state == S_IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign last_pos  = 6'(len_q - `JTAG_LEN_W'(1));

    assign step.run       = (state != S_IDLE) && (state != S_WAIT_RSP);
    assign shift.shift_en = (state_n == S_SHIFT);
    assign shift.load     = accept && (cmd_op == CMD_LOAD_IR || cmd_op == CMD_LOAD_DR);

    always_comb begin
        state_n      = state;
        step.start   = 1'b0;
        step.count   = '0;
        shift.finish = 1'b0;
        case (state)
            S_IDLE: begin
                if (cmd_valid) begin
                    step.start = 1'b1;
                    case (cmd_op)
                        CMD_CLOSE_TEST: begin
                            state_n    = S_RESET_WALK;
                            step.count = `JTAG_LEN_W'(`JTAG_RESET_TCKS);
                        end
                        CMD_RUN_TEST: begin
                            state_n    = S_RUN;
                            step.count = `JTAG_LEN_W'(1);
                        end
                        CMD_LOAD_IR: begin
                            state_n    = S_PRE;
                            step.count = `JTAG_LEN_W'(`JTAG_IR_PRE);
                        end
                        CMD_LOAD_DR: begin
                            state_n    = S_PRE;
                            step.count = `JTAG_LEN_W'(`JTAG_DR_PRE);
                        end
                        CMD_IDLE_DELAY: begin
                            if (cmd_len != '0) begin
                                state_n    = S_DELAY;
                                step.count = cmd_len;
                            end else begin
                                step.start = 1'b0;  // zero delay, nothing to do
                            end
                        end
                        default: step.start = 1'b0;  // unknown opcode dropped
                    endcase
                end
            end
            S_RESET_WALK, S_RUN, S_DELAY: begin
                if (step.done) begin
                    state_n = S_IDLE;
                end
            end
            S_PRE: begin
                if (step.done) begin
                    state_n    = S_SHIFT;
                    step.start = 1'b1;
                    step.count = len_q;
                end
            end
            S_SHIFT: begin
                if (step.done) begin
                    state_n    = S_POST;
                    step.start = 1'b1;
                    step.count = `JTAG_LEN_W'(`JTAG_POST);
                end
            end
            S_POST: begin
                if (step.done) begin
                    shift.finish = 1'b1;  // rsp_valid follows next cycle
                    state_n      = S_WAIT_RSP;
                end
            end
            S_WAIT_RSP: begin
                if (!shift.rsp_busy) begin
                    state_n = S_IDLE;
                end
            end
            default: state_n = S_IDLE;
        endcase
    end

    always_comb begin
        if (step.start) begin
            pos_n = '0;
        end else if (step.fall) begin
            pos_n = pos + 6'd1;
        end else begin
            pos_n = pos;
        end
    end

    // tms for the period about to start
    always_comb begin
        case (state_n)
            S_RESET_WALK: tms_n = 1'b1;
            S_PRE:        tms_n = (pos_n == 6'd0) || (op_q == CMD_LOAD_IR && pos_n == 6'd1);
            S_SHIFT:      tms_n = (pos_n == last_pos);
            S_POST:       tms_n = (pos_n == 6'd0);
            default:      tms_n = 1'b0;
        endcase
    end

    always_ff @(posedge jtag_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            op_q  <= CMD_CLOSE_TEST;
            pos   <= '0;
            tms   <= 1'b0;
        end else begin
            state <= state_n;
            pos   <= pos_n;
            if (accept) begin
                op_q <= cmd_op;
            end
            // tms holds once the command is over
            if (step.start || (step.fall && !step.done)) begin
                tms <= tms_n;
            end
        end
    end

    always_ff @(posedge jtag_clk) begin
        if (accept) begin
            len_q <= cmd_len;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/jtag_tck_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "jtag_consts.svh"

module jtag_tck_timer (
    input  wire        jtag_clk,
    input  wire        arst_n,
    output logic       tck,
    jtag_step_if.timer step
);

    logic [`JTAG_LEN_W-1:0] cnt;  // periods left in the segment

    // a period is one low cycle and one high cycle
    assign step.rise = step.run && !tck && (cnt != '0);
    assign step.fall = tck;
    assign step.done = tck && (cnt == `JTAG_LEN_W'(1));

    always_ff @(posedge jtag_clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (step.start) begin
            cnt <= step.count;  // new segment wins over the ending fall
        end else if (step.fall) begin
            cnt <= cnt - `JTAG_LEN_W'(1);
        end
    end

    // stays low once cnt runs out
    always_ff @(posedge jtag_clk or negedge arst_n) begin
        if (!arst_n) begin
            tck <= 1'b0;
        end else if (step.rise) begin
            tck <= 1'b1;
        end else if (step.fall) begin
            tck <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/jtag_shift_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "jtag_consts.svh"

module jtag_shift_reg (
    input  wire                     jtag_clk,
    input  wire                     arst_n,
    input  wire [`JTAG_DATA_W-1:0]  cmd_data,
    input  wire [`JTAG_LEN_W-1:0]   cmd_len,
    input  wire                     tdo,
    input  wire                     rise,
    input  wire                     fall,
    input  wire                     rsp_ready,
    output logic                    tdi,
    output logic                    rsp_valid,
    output logic [`JTAG_DATA_W-1:0] rsp_data,
    jtag_shift_if.shifter           shift
);

    logic [`JTAG_DATA_W-1:0] tx_sr;   // bits still to go out, lsb first
    logic [`JTAG_DATA_W-1:0] cap_sr;  // tdo enters at the top
    logic [`JTAG_LEN_W-1:0]  len_q;
    logic [`JTAG_LEN_W-1:0]  align;

    // first captured bit ends up in bit 0
    assign align = `JTAG_LEN_W'(`JTAG_DATA_W) - len_q;

    assign shift.tdi_bit  = tdi;
    assign shift.rsp_busy = rsp_valid;

    always_ff @(posedge jtag_clk or negedge arst_n) begin
        if (!arst_n) begin
            tdi <= 1'b0;
        end else if (fall) begin
            tdi <= shift.shift_en && tx_sr[0];  // low outside shift-xr
        end
    end

    always_ff @(posedge jtag_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (shift.finish) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge jtag_clk) begin
        if (shift.load) begin
            tx_sr  <= cmd_data;
            cap_sr <= '0;
            len_q  <= cmd_len;
        end else begin
            if (fall && shift.shift_en) begin
                tx_sr <= tx_sr >> 1;
            end
            if (rise && shift.shift_en) begin
                cap_sr <= {tdo, cap_sr[`JTAG_DATA_W-1:1]};
            end
        end
        // held until the next finish, which needs the handshake first
        if (shift.finish) begin
            rsp_data <= cap_sr >> align;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/jtag_master_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "jtag_consts.svh"

// bitstream load runs close, run, ir jrst, run, ir cfgi, delay, dr data,
// close, run, ir jwakeup, delay, close
// idcode read runs close, run, ir idcode, run, dr 32 bits, close
module jtag_master_top
    import jtag_pkg::*;
(
    input  wire                     jtag_clk,
    input  wire                     arst_n,
    input  wire                     cmd_valid,
    input  wire jtag_op_e           cmd_op,
    input  wire [`JTAG_LEN_W-1:0]   cmd_len,
    input  wire [`JTAG_DATA_W-1:0]  cmd_data,
    input  wire                     rsp_ready,
    input  wire                     tdo,
    output logic                    cmd_ready,
    output logic                    rsp_valid,
    output logic [`JTAG_DATA_W-1:0] rsp_data,
    output logic                    tck,
    output logic                    tms,
    output logic                    tdi
);

    jtag_step_if  u_step_if ();
    jtag_shift_if u_shift_if ();

    assign tdi = u_shift_if.tdi_bit;

    jtag_seq_fsm u_seq_fsm (
        .jtag_clk  (jtag_clk  ),
        .arst_n    (arst_n    ),
        .cmd_valid (cmd_valid ),
        .cmd_op    (cmd_op    ),
        .cmd_len   (cmd_len   ),
        .cmd_ready (cmd_ready ),
        .tms       (tms       ),
        .step      (u_step_if ),
        .shift     (u_shift_if)
    );

    jtag_tck_timer u_tck_timer (
        .jtag_clk (jtag_clk ),
        .arst_n   (arst_n   ),
        .tck      (tck      ),
        .step     (u_step_if)
    );

    jtag_shift_reg u_shift_reg (
        .jtag_clk  (jtag_clk      ),
        .arst_n    (arst_n        ),
        .cmd_data  (cmd_data      ),
        .cmd_len   (cmd_len       ),
        .tdo       (tdo           ),
        .rise      (u_step_if.rise),
        .fall      (u_step_if.fall),
        .rsp_ready (rsp_ready     ),
        .tdi       (              ),
        .rsp_valid (rsp_valid     ),
        .rsp_data  (rsp_data      ),
        .shift     (u_shift_if    )
    );

endmodule

`default_nettype wire

// ==== tb/jtag_tap_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// behavioral tap target, 10-bit ir, idcode and bypass registers
module jtag_tap_model (
    input  wire         arst_n,
    input  wire         tck,
    input  wire         tms,
    input  wire         tdi,
    input  wire  [31:0] idcode,
    output logic        tdo,
    output logic        in_tlr,
    output logic        in_rti,
    output logic [9:0]  ir,
    output logic [31:0] dr_in    // last bits shifted into a dr
);

    typedef enum logic [3:0] {
        TLR, RTI, SEL_DR, CAP_DR, SH_DR, EX1_DR, PAU_DR, EX2_DR, UPD_DR,
        SEL_IR, CAP_IR, SH_IR, EX1_IR, PAU_IR, EX2_IR, UPD_IR
    } tap_state_e;

    localparam logic [9:0] IDCODE_OP = 10'h009;

    tap_state_e  state;
    tap_state_e  state_n;
    logic [9:0]  ir_sr;
    logic [31:0] dr_sr;
    logic        byp;

    assign in_tlr = (state == TLR);
    assign in_rti = (state == RTI);

    always_comb begin
        case (state)
            TLR:     state_n = tms ? TLR : RTI;
            RTI:     state_n = tms ? SEL_DR : RTI;
            SEL_DR:  state_n = tms ? SEL_IR : CAP_DR;
            CAP_DR:  state_n = tms ? EX1_DR : SH_DR;
            SH_DR:   state_n = tms ? EX1_DR : SH_DR;
            EX1_DR:  state_n = tms ? UPD_DR : PAU_DR;
            PAU_DR:  state_n = tms ? EX2_DR : PAU_DR;
            EX2_DR:  state_n = tms ? UPD_DR : SH_DR;
            UPD_DR:  state_n = tms ? SEL_DR : RTI;
            SEL_IR:  state_n = tms ? TLR : CAP_IR;
            CAP_IR:  state_n = tms ? EX1_IR : SH_IR;
            SH_IR:   state_n = tms ? EX1_IR : SH_IR;
            EX1_IR:  state_n = tms ? UPD_IR : PAU_IR;
            PAU_IR:  state_n = tms ? EX2_IR : PAU_IR;
            EX2_IR:  state_n = tms ? UPD_IR : SH_IR;
            default: state_n = tms ? SEL_DR : RTI;  // update-ir
        endcase
    end

    always @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            state  <= TLR;
            ir     <= IDCODE_OP;
            ir_sr  <= '0;
            dr_sr  <= '0;
            byp    <= 1'b0;
            dr_in  <= '0;
        end else begin
            state <= state_n;
            case (state)
                TLR:    ir <= IDCODE_OP;
                CAP_IR: ir_sr <= 10'b00_0000_0001;
                SH_IR:  ir_sr <= {tdi, ir_sr[9:1]};
                UPD_IR: ir <= ir_sr;
                CAP_DR: begin
                    dr_sr <= idcode;
                    byp   <= 1'b0;
                end
                SH_DR: begin
                    dr_sr <= {tdi, dr_sr[31:1]};
                    byp   <= tdi;
                    dr_in <= {tdi, dr_in[31:1]};
                end
                default: ;
            endcase
        end
    end

    // tdo changes on the falling tck edge
    always @(negedge tck or negedge arst_n) begin
        if (!arst_n) begin
            tdo <= 1'b0;
        end else if (state == SH_IR) begin
            tdo <= ir_sr[0];
        end else if (state == SH_DR) begin
            tdo <= (ir == IDCODE_OP) ? dr_sr[0] : byp;
        end else begin
            tdo <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/jtag_master_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module jtag_master_properties (
    input wire        jtag_clk,
    input wire        arst_n,
    input wire        tck,
    input wire        tms,
    input wire        tdi,
    input wire        cmd_ready,
    input wire        rsp_valid,
    input wire        rsp_ready,
    input wire [31:0] rsp_data
);

    // outputs move only on the edge where tck drops
    assert property (@(posedge jtag_clk) disable iff (!arst_n)
        tck |-> $stable(tms) && $stable(tdi))
        else $error("tms or tdi changed while tck high");

    assert property (@(posedge jtag_clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else $error("response dropped or changed before rsp_ready");

    assert property (@(posedge jtag_clk) disable iff (!arst_n)
        cmd_ready |-> !tck)
        else $error("tck high while engine idle");

endmodule

bind jtag_master_top jtag_master_properties props (
    .jtag_clk  (jtag_clk ),
    .arst_n    (arst_n   ),
    .tck       (tck      ),
    .tms       (tms      ),
    .tdi       (tdi      ),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data )
);

`default_nettype wire

// ==== tb/tb_jtag_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_jtag_master
    import jtag_pkg::*;
;

    localparam logic [31:0] IDCODE    = 32'h0362_d093;
    localparam logic [9:0]  IDCODE_OP = 10'h009;
    localparam logic [9:0]  BYPASS_OP = 10'h3ff;
    localparam int N_RAND   = 4;
    localparam int DELAY_N  = 40;
    // close 5, run 1, ir 16 twice, dr 37 per shift, delay
    localparam int TCKS     = 5 + 1 + 16 + 37 + 16 + N_RAND * 37 + DELAY_N + 37;
    localparam int LIMIT    = 2 * TCKS + 30 * 11 + 200;

    logic        jtag_clk;
    logic        arst_n;
    logic        cmd_valid;
    jtag_op_e    cmd_op;
    logic [19:0] cmd_len;
    logic [31:0] cmd_data;
    logic        rsp_ready;
    logic        cmd_ready;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        tck;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic        in_tlr;
    logic        in_rti;
    logic [9:0]  ir;
    logic [31:0] dr_in;

    integer seed = 32'h14e0377b;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     test_errs;
    int     cycles = 0;
    int     tck_rises = 0;
    int     tms_high_rises = 0;
    string  test_name = "reset";

    jtag_master_top dut (.*);

    jtag_tap_model tap (.arst_n(arst_n), .tck(tck), .tms(tms), .tdi(tdi), .idcode(IDCODE),
        .tdo(tdo), .in_tlr(in_tlr), .in_rti(in_rti), .ir(ir), .dr_in(dr_in));

    initial begin
        jtag_clk = 1'b0;
        forever #10 jtag_clk = ~jtag_clk;
    end

    always @(posedge tck) begin
        tck_rises++;
        if (tms) tms_high_rises++;
    end

    initial begin
        forever begin
            @(posedge jtag_clk);
            cycles++;
            if (cycles > LIMIT) begin
                $display("timeout: test %s hung after %0d cycles", test_name, cycles);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    end

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %s", test_name, (errors == test_errs) ? "ok" : "failed");
    endtask

    task automatic send_cmd(jtag_op_e op, int len, logic [31:0] data);
        @(negedge jtag_clk);
        while (!cmd_ready) @(negedge jtag_clk);
        tck_rises      = 0;
        tms_high_rises = 0;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_len   = 20'(len);
        cmd_data  = data;
        @(negedge jtag_clk);
        cmd_valid = 1'b0;
        cmd_data  = '0;
    endtask

    task automatic wait_ready();
        while (!cmd_ready) @(negedge jtag_clk);
    endtask

    task automatic take_rsp(output logic [31:0] data);
        while (!rsp_valid) @(negedge jtag_clk);
        data      = rsp_data;
        rsp_ready = 1'b1;
        @(negedge jtag_clk);
        rsp_ready = 1'b0;
        wait_ready();
    endtask

    task automatic reset_walk();
        begin_test("reset_walk");
        check("cmd_ready", cmd_ready, 1);
        check("tck/tms/tdi/rsp_valid", {tck, tms, tdi, rsp_valid}, 0);
        send_cmd(CMD_CLOSE_TEST, 0, 0);
        wait_ready();
        check("close tck count", tck_rises, 5);
        check("close tms high count", tms_high_rises, 5);
        check("tap in test-logic-reset", in_tlr, 1);
        send_cmd(CMD_RUN_TEST, 0, 0);
        wait_ready();
        check("run tck count", tck_rises, 1);
        check("run tms high count", tms_high_rises, 0);
        check("tap in run-test/idle", in_rti, 1);
        end_test();
    endtask

    task automatic load_ir(logic [9:0] op);
        logic [31:0] rsp;
        begin_test("load_ir");
        send_cmd(CMD_LOAD_IR, 10, {22'd0, op});
        take_rsp(rsp);
        check("ir value", ir, op);
        check("ir capture", rsp, 32'h1);
        check("ir tck count", tck_rises, 16);
        check("tap in run-test/idle", in_rti, 1);
        end_test();
    endtask

    task automatic read_idcode();
        logic [31:0] rsp;
        begin_test("read_idcode");
        send_cmd(CMD_LOAD_DR, 32, 32'h0);
        take_rsp(rsp);
        check("idcode", rsp, IDCODE);
        check("tap in run-test/idle", in_rti, 1);
        end_test();
    endtask

    task automatic bypass_random();
        logic [31:0] rsp;
        logic [31:0] data;
        logic [31:0] mask;
        int          len;
        begin_test("bypass_random");
        for (int i = 0; i < N_RAND; i++) begin
            data = $random(seed);
            len  = ($random(seed) & 31) + 1;
            mask = (len == 32) ? 32'hffff_ffff : ((32'h1 << len) - 1);
            send_cmd(CMD_LOAD_DR, len, data);
            take_rsp(rsp);
            check("bypass data", rsp, (data << 1) & mask);
            check("bypass tdi seen", dr_in >> (32 - len), data & mask);
            check("dr tck count", tck_rises, len + 5);
        end
        end_test();
    endtask

    task automatic idle_delay();
        begin_test("idle_delay");
        send_cmd(CMD_IDLE_DELAY, DELAY_N, 0);
        wait_ready();
        check("delay tck count", tck_rises, DELAY_N);
        check("tms high during delay", tms_high_rises, 0);
        end_test();
    endtask

    task automatic back_pressure();
        logic [31:0] held;
        logic [31:0] rsp;
        int          rises;
        begin_test("back_pressure");
        send_cmd(CMD_LOAD_DR, 32, 32'ha5c3_0f96);
        while (!rsp_valid) @(negedge jtag_clk);
        held  = rsp_data;
        rises = tck_rises;
        repeat (8) begin
            @(negedge jtag_clk);
            check("rsp_valid held", rsp_valid, 1);
            check("rsp_data stable", rsp_data, held);
            check("cmd_ready low", cmd_ready, 0);
            check("no tck while waiting", tck_rises, rises);
        end
        take_rsp(rsp);
        check("bypass data", rsp, 32'ha5c3_0f96 << 1);
        end_test();
    endtask

    initial begin
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = CMD_CLOSE_TEST;
        cmd_len   = '0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        repeat (10) @(posedge jtag_clk);
        @(negedge jtag_clk);
        arst_n = 1'b1;
        @(negedge jtag_clk);

        reset_walk();
        load_ir(IDCODE_OP);
        read_idcode();
        load_ir(BYPASS_OP);
        bypass_random();
        idle_delay();
        back_pressure();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== jtag_master_top.f ====
+incdir+rtl
rtl/jtag_pkg.sv
rtl/jtag_if.sv
rtl/jtag_seq_fsm.sv
rtl/jtag_tck_timer.sv
rtl/jtag_shift_reg.sv
rtl/jtag_master_top.sv
tb/jtag_tap_model.sv
tb/jtag_master_properties.sv
tb/tb_jtag_master.sv

// ==== Makefile ====
# Verilator build for the JTAG command engine

TOP := tb_jtag_master
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f jtag_master_top.f --top-module $(TOP)

obj_dir/V$(TOP): jtag_master_top.f rtl/*.sv rtl/*.svh tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f jtag_master_top.f \
		--top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
